//--- logic/patch_distance_unit.sv
`timescale 1ns/100ps
`include "patch_match_defines.svh"

module patch_distance_unit
    import patch_match_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    // Query
    input  logic      dist_start_i,
    input  row_addr_t dist_addr_i,
    input  patch_t    dist_probe_i,
    // Memory port 1
    output logic      p1_en_o,
    output row_addr_t p1_addr_o,
    input  ram_word_t p1_rdata_i,
    // Result
    output logic      dist_valid_o,
    output dist_t     dist_o
);

    localparam int N  = `PATCH_SIZE;
    localparam int EW = $bits(elem_t);

    logic   s0_valid;
    logic   s1_valid;
    patch_t s0_probe;
    patch_t s0_stored;
    elem_t  s1_diff [N];
    dist_t  sad_sum;

    function automatic elem_t abs_diff(input elem_t a, input elem_t b);
        return (a > b) ? a - b : b - a;
    endfunction

    // Stage 0 read goes straight to the memory, data returns next cycle
    assign p1_en_o   = dist_start_i;
    assign p1_addr_o = dist_addr_i;
    assign s0_stored = p1_rdata_i[$bits(patch_t)-1:0];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s0_valid     <= 1'b0;
            s1_valid     <= 1'b0;
            dist_valid_o <= 1'b0;
        end else begin
            s0_valid     <= dist_start_i;
            s1_valid     <= s0_valid;
            dist_valid_o <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dist_start_i) s0_probe <= dist_probe_i;
        // Stage 1
        if (s0_valid) begin
            for (int e = 0; e < N; e++) begin
                s1_diff[e] <= abs_diff(s0_stored[e*EW +: EW], s0_probe[e*EW +: EW]);
            end
        end
        if (s1_valid) dist_o <= sad_sum;   // Stage 2
    end

    always_comb begin
        sad_sum = '0;
        for (int e = 0; e < N; e++) begin
            sad_sum = sad_sum + dist_t'(s1_diff[e]);
        end
    end

endmodule

//--- logic/patch_match_defines.svh
`ifndef PATCH_MATCH_DEFINES_SVH
`define PATCH_MATCH_DEFINES_SVH

// Element and patch geometry
`define DATA_WIDTH 11
`define PATCH_SIZE 5

// Patch memory, one patch per row
`define ADDR_WIDTH 9
`define RAM_DEPTH  512
`define RAM_WIDTH  64

// Host word address that lands on row 0
`define WB_ADDR_OFFSET 557

`endif

//--- logic/patch_match_pkg.sv
`include "patch_match_defines.svh"

package patch_match_pkg;

    // Pixel element and packed patch, element 0 in the low bits
    typedef logic [`DATA_WIDTH-1:0]             elem_t;
    typedef logic [`PATCH_SIZE*`DATA_WIDTH-1:0] patch_t;

    // Memory row, byte write mask and row address
    typedef logic [`RAM_WIDTH-1:0]   ram_word_t;
    typedef logic [`RAM_WIDTH/8-1:0] byte_mask_t;
    typedef logic [`ADDR_WIDTH-1:0]  row_addr_t;

    typedef logic [`DATA_WIDTH+2:0] dist_t;  // Five full-scale differences fit

    // Wishbone bridge FSM
    typedef enum logic [1:0] {
        WB_IDLE,
        WB_REQ,
        WB_READ,
        WB_ACK
    } wb_state_t;

endpackage

//--- logic/patch_match_top.sv
`timescale 1ns/100ps
`include "patch_match_defines.svh"

module patch_match_top
    import patch_match_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,
    // Native patch loader
    input  logic        patch_wr_i,
    input  row_addr_t   patch_addr_i,
    input  patch_t      patch_data_i,
    // Wishbone slave
    input  logic        wbs_cyc_i,
    input  logic        wbs_stb_i,
    input  logic        wbs_we_i,
    input  logic [3:0]  wbs_sel_i,
    input  logic [31:0] wbs_adr_i,
    input  logic [31:0] wbs_dat_i,
    output logic        wbs_ack_o,
    output logic [31:0] wbs_dat_o,
    // Distance query
    input  logic        dist_start_i,
    input  row_addr_t   dist_addr_i,
    input  patch_t      dist_probe_i,
    output logic        dist_valid_o,
    output dist_t       dist_o
);

    // Bridge to arbiter
    logic       wb_req;
    logic       wb_we;
    row_addr_t  wb_row;
    ram_word_t  wb_wdata;
    byte_mask_t wb_wmask;
    logic       wb_gnt;

    // Memory ports
    logic       p0_en;
    logic       p0_we;
    row_addr_t  p0_addr;
    ram_word_t  p0_wdata;
    byte_mask_t p0_wmask;
    ram_word_t  p0_rdata;
    logic       p1_en;
    row_addr_t  p1_addr;
    ram_word_t  p1_rdata;

    query_patch_ram #(
        .DEPTH(`RAM_DEPTH)
    ) query_patch_ram_i (
        .clk(clk),
        .p0_en_i(p0_en), .p0_we_i(p0_we), .p0_addr_i(p0_addr),
        .p0_wdata_i(p0_wdata), .p0_wmask_i(p0_wmask), .p0_rdata_o(p0_rdata),
        .p1_en_i(p1_en), .p1_addr_i(p1_addr), .p1_rdata_o(p1_rdata)
    );

    patch_port_arbiter patch_port_arbiter_i (
        .clk(clk), .rst_n_i(rst_n_i),
        .patch_wr_i(patch_wr_i), .patch_addr_i(patch_addr_i), .patch_data_i(patch_data_i),
        .wb_req_i(wb_req), .wb_we_i(wb_we), .wb_row_i(wb_row),
        .wb_wdata_i(wb_wdata), .wb_wmask_i(wb_wmask), .wb_gnt_o(wb_gnt),
        .p0_en_o(p0_en), .p0_we_o(p0_we), .p0_addr_o(p0_addr),
        .p0_wdata_o(p0_wdata), .p0_wmask_o(p0_wmask)
    );

    wb_patch_bridge wb_patch_bridge_i (
        .clk(clk), .rst_n_i(rst_n_i),
        .wbs_cyc_i(wbs_cyc_i), .wbs_stb_i(wbs_stb_i), .wbs_we_i(wbs_we_i),
        .wbs_sel_i(wbs_sel_i), .wbs_adr_i(wbs_adr_i), .wbs_dat_i(wbs_dat_i),
        .wbs_ack_o(wbs_ack_o), .wbs_dat_o(wbs_dat_o),
        .wb_req_o(wb_req), .wb_we_o(wb_we), .wb_row_o(wb_row),
        .wb_wdata_o(wb_wdata), .wb_wmask_o(wb_wmask),
        .wb_gnt_i(wb_gnt), .p0_rdata_i(p0_rdata)
    );

    patch_distance_unit patch_distance_unit_i (
        .clk(clk), .rst_n_i(rst_n_i),
        .dist_start_i(dist_start_i), .dist_addr_i(dist_addr_i), .dist_probe_i(dist_probe_i),
        .p1_en_o(p1_en), .p1_addr_o(p1_addr), .p1_rdata_i(p1_rdata),
        .dist_valid_o(dist_valid_o), .dist_o(dist_o)
    );

endmodule

//--- logic/patch_port_arbiter.sv
`timescale 1ns/100ps

module patch_port_arbiter
    import patch_match_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    // Native patch loader
    input  logic       patch_wr_i,
    input  row_addr_t  patch_addr_i,
    input  patch_t     patch_data_i,
    // Wishbone bridge
    input  logic       wb_req_i,
    input  logic       wb_we_i,
    input  row_addr_t  wb_row_i,
    input  ram_word_t  wb_wdata_i,
    input  byte_mask_t wb_wmask_i,
    output logic       wb_gnt_o,
    // Memory port 0
    output logic       p0_en_o,
    output logic       p0_we_o,
    output row_addr_t  p0_addr_o,
    output ram_word_t  p0_wdata_o,
    output byte_mask_t p0_wmask_o
);

    logic [7:0] wait_cnt;  // Consecutive cycles the loader won over a waiting bridge

    // Native strobe has fixed priority
    assign wb_gnt_o   = wb_req_i && !patch_wr_i;
    assign p0_en_o    = patch_wr_i || wb_req_i;
    assign p0_we_o    = patch_wr_i || wb_we_i;
    assign p0_addr_o  = patch_wr_i ? patch_addr_i : wb_row_i;
    assign p0_wdata_o = patch_wr_i ? ram_word_t'(patch_data_i) : wb_wdata_i;  // Upper bits zero
    assign p0_wmask_o = patch_wr_i ? '1 : wb_wmask_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wait_cnt <= '0;
        end else if (!wb_req_i || wb_gnt_o) begin
            wait_cnt <= '0;
        end else if (wait_cnt != '1) begin
            wait_cnt <= wait_cnt + 8'd1;  // Saturates
        end
    end

    // A request that lost to the loader stays up, unchanged, until granted
    bridge_req_held: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (wait_cnt != '0) |-> wb_req_i && $stable({wb_we_i, wb_row_i, wb_wdata_i, wb_wmask_i})
    ) else begin
        $error("Bridge request dropped after %0d lost cycles", wait_cnt);
    end

    no_grant_on_native: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        patch_wr_i |-> !wb_gnt_o
    ) else begin
        $error("Bridge granted during a native write");
    end

endmodule

//--- logic/query_patch_ram.sv
`timescale 1ns/100ps
`include "patch_match_defines.svh"

module query_patch_ram
    import patch_match_pkg::*;
#(
    parameter int DEPTH = `RAM_DEPTH
) (
    input  logic       clk,
    // Port 0, read/write with byte mask
    input  logic       p0_en_i,
    input  logic       p0_we_i,
    input  row_addr_t  p0_addr_i,
    input  ram_word_t  p0_wdata_i,
    input  byte_mask_t p0_wmask_i,
    output ram_word_t  p0_rdata_o,
    // Port 1, read only
    input  logic       p1_en_i,
    input  row_addr_t  p1_addr_i,
    output ram_word_t  p1_rdata_o
);

    localparam int NUM_BYTES = $bits(byte_mask_t);

    ram_word_t mem [DEPTH];

    // Port 0
    // The read samples the row before any write at the same edge
    always_ff @(posedge clk) begin
        if (p0_en_i) begin
            p0_rdata_o <= mem[p0_addr_i];
            if (p0_we_i) begin
                for (int b = 0; b < NUM_BYTES; b++) begin
                    if (p0_wmask_i[b]) begin
                        mem[p0_addr_i][b*8 +: 8] <= p0_wdata_i[b*8 +: 8];
                    end
                end
            end
        end
    end

    // Port 1
    always_ff @(posedge clk) begin
        if (p1_en_i) begin
            p1_rdata_o <= mem[p1_addr_i];  // Old row on a same-edge port 0 write
        end
    end

    p0_addr_in_range: assert property (
        @(posedge clk) p0_en_i |-> (int'(p0_addr_i) < DEPTH)
    ) else begin
        $error("Port 0 row %0d outside memory", p0_addr_i);
    end

    p1_addr_in_range: assert property (
        @(posedge clk) p1_en_i |-> (int'(p1_addr_i) < DEPTH)
    ) else begin
        $error("Port 1 row %0d outside memory", p1_addr_i);
    end

endmodule

//--- logic/wb_patch_bridge.sv
`timescale 1ns/100ps
`include "patch_match_defines.svh"

module wb_patch_bridge
    import patch_match_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,
    // Wishbone slave
    input  logic        wbs_cyc_i,
    input  logic        wbs_stb_i,
    input  logic        wbs_we_i,
    input  logic [3:0]  wbs_sel_i,
    input  logic [31:0] wbs_adr_i,
    input  logic [31:0] wbs_dat_i,
    output logic        wbs_ack_o,
    output logic [31:0] wbs_dat_o,
    // Request towards the port 0 arbiter
    output logic        wb_req_o,
    output logic        wb_we_o,
    output row_addr_t   wb_row_o,
    output ram_word_t   wb_wdata_o,
    output byte_mask_t  wb_wmask_o,
    input  logic        wb_gnt_i,
    input  ram_word_t   p0_rdata_i
);

    wb_state_t   state;
    wb_state_t   state_nxt;
    logic        host_start;
    logic [31:0] adr_rel;   // Word address relative to row 0
    logic [2:0]  lane;      // Byte lane of a write
    logic        rd_hi;

    assign host_start = wbs_cyc_i && wbs_stb_i;
    assign adr_rel    = wbs_adr_i - 32'(`WB_ADDR_OFFSET);
    assign lane       = wbs_dat_i[13:11];

    assign wb_req_o  = (state == WB_REQ);
    assign wbs_ack_o = (state == WB_ACK);

    always_comb begin
        state_nxt = state;
        unique case (state)
            WB_IDLE: if (host_start) state_nxt = WB_REQ;
            WB_REQ:  if (wb_gnt_i) state_nxt = wb_we_o ? WB_ACK : WB_READ;
            WB_READ: state_nxt = WB_ACK;   // Row data arrives here
            WB_ACK:  state_nxt = WB_IDLE;
            default: state_nxt = WB_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= WB_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Host cycle is latched once and held until the grant
    always_ff @(posedge clk) begin
        if (state == WB_IDLE && host_start) begin
            wb_we_o    <= wbs_we_i;
            wb_row_o   <= row_addr_t'(adr_rel);
            wb_wdata_o <= ram_word_t'(wbs_dat_i[7:0]) << {lane, 3'b000};
            wb_wmask_o <= byte_mask_t'(1) << lane;  // One-hot lane
            rd_hi      <= wbs_dat_i[11];
        end
        if (state == WB_READ) begin
            // Upper half is the rest of the patch, zero-extended
            wbs_dat_o <= rd_hi ? 32'(p0_rdata_i[$bits(patch_t)-1:32]) : p0_rdata_i[31:0];
        end
    end

    ack_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        wbs_ack_o |=> !wbs_ack_o
    ) else begin
        $error("Wishbone ack held longer than one cycle");
    end

endmodule

//--- patch_match.f
+incdir+logic
logic/patch_match_pkg.sv
logic/query_patch_ram.sv
logic/patch_port_arbiter.sv
logic/wb_patch_bridge.sv
logic/patch_distance_unit.sv
logic/patch_match_top.sv
test/tb_patch_match.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the patch_match testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG_FILE=sim.log
FAIL_MSG="Simulation FAILED"

verilator --binary --timing --assert -j 0 \
    --top-module tb_patch_match \
    -f patch_match.f \
    --Mdir "$BUILD_DIR" -o tb_patch_match
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_patch_match" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

# The log decides the result, the exit status only backs it up
if grep -q "$FAIL_MSG" "$LOG_FILE"; then
    echo "Run failed, see $LOG_FILE"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi
echo "Run passed"
exit 0

//--- test/tb_patch_match.sv
`timescale 1ns/100ps
`include "patch_match_defines.svh"

module tb_patch_match
    import patch_match_pkg::*;
();

    localparam int SEED         = 99;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 4;
    localparam int PATCH_BITS   = `PATCH_SIZE * `DATA_WIDTH;
    localparam int WB_ACK_BOUND = 32;   // Longest native burst is well below this

    // Cycles per phase
    localparam int N_IDLE  = 8;
    localparam int N_DIST  = 200;
    localparam int N_WB    = 600;
    localparam int N_CONT  = 1500;
    localparam int N_READ  = 400;
    localparam int N_MIX   = 3000;
    localparam int N_DRAIN = 40;
    localparam int N_OPS   = N_IDLE + `RAM_DEPTH + N_DIST + N_WB + N_CONT
                             + 2 * N_READ + N_MIX + N_DRAIN;
    localparam int WATCHDOG_CYCLES = N_OPS * 20 + 1000;

    // Host side view of a Wishbone cycle
    localparam int HOST_IDLE    = 0;
    localparam int HOST_STROBE  = 1;   // stb driven, bridge not yet latched
    localparam int HOST_PENDING = 2;   // Request waiting for port 0
    localparam int HOST_GRANTED = 3;

    logic        clk = 1'b0;
    logic        rst_n_i;
    logic        patch_wr_i;
    row_addr_t   patch_addr_i;
    patch_t      patch_data_i;
    logic        wbs_cyc_i;
    logic        wbs_stb_i;
    logic        wbs_we_i;
    logic [3:0]  wbs_sel_i;
    logic [31:0] wbs_adr_i;
    logic [31:0] wbs_dat_i;
    logic        wbs_ack_o;
    logic [31:0] wbs_dat_o;
    logic        dist_start_i;
    row_addr_t   dist_addr_i;
    patch_t      dist_probe_i;
    logic        dist_valid_o;
    dist_t       dist_o;

    // Reference model
    ram_word_t   model_mem [`RAM_DEPTH];
    int          exp_due[$];          // Cycle a result is due
    dist_t       exp_dist[$];
    int          cycle_cnt = 0;
    int          host_state = HOST_IDLE;
    int          wb_wait;
    int          ack_due;
    logic        mw_we;
    row_addr_t   mw_row;
    logic [2:0]  mw_lane;
    logic [7:0]  mw_byte;
    logic        mw_hi;
    logic [31:0] exp_rdata;

    patch_match_top patch_match_top_i (
        .clk(clk), .rst_n_i(rst_n_i),
        .patch_wr_i(patch_wr_i), .patch_addr_i(patch_addr_i), .patch_data_i(patch_data_i),
        .wbs_cyc_i(wbs_cyc_i), .wbs_stb_i(wbs_stb_i), .wbs_we_i(wbs_we_i),
        .wbs_sel_i(wbs_sel_i), .wbs_adr_i(wbs_adr_i), .wbs_dat_i(wbs_dat_i),
        .wbs_ack_o(wbs_ack_o), .wbs_dat_o(wbs_dat_o),
        .dist_start_i(dist_start_i), .dist_addr_i(dist_addr_i), .dist_probe_i(dist_probe_i),
        .dist_valid_o(dist_valid_o), .dist_o(dist_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic value_mismatch(input string sig, input logic [63:0] exp_val,
                                  input logic [63:0] act_val);
        abort_run($sformatf("ERR time %0t: %s expected 0x%0h actual 0x%0h",
                            $time, sig, exp_val, act_val));
    endtask

    // Sum of absolute element differences over the patch bits of a row
    function automatic dist_t expected_sad(input ram_word_t row, input patch_t probe);
        int sum;
        int a;
        int b;
        sum = 0;
        for (int e = 0; e < `PATCH_SIZE; e++) begin
            a = int'(row[e*`DATA_WIDTH +: `DATA_WIDTH]);
            b = int'(probe[e*`DATA_WIDTH +: `DATA_WIDTH]);
            sum += (a > b) ? a - b : b - a;
        end
        return dist_t'(sum);
    endfunction

    function automatic patch_t rand_patch();
        patch_t p;
        for (int e = 0; e < `PATCH_SIZE; e++) begin
            case ($urandom_range(0, 5))
                0:       p[e*`DATA_WIDTH +: `DATA_WIDTH] = '0;
                1:       p[e*`DATA_WIDTH +: `DATA_WIDTH] = '1;   // Full-scale element
                default: p[e*`DATA_WIDTH +: `DATA_WIDTH] = elem_t'($urandom);
            endcase
        end
        return p;
    endfunction

    // Narrow rows make same-edge collisions likely
    function automatic row_addr_t pick_row(input logic narrow);
        if (narrow) begin
            return row_addr_t'($urandom_range(0, 15));
        end
        return row_addr_t'($urandom_range(0, `RAM_DEPTH - 1));
    endfunction

    task automatic check_distance();
        if (exp_due.size() > 0 && exp_due[0] == cycle_cnt) begin
            assert (dist_valid_o == 1'b1)
                else value_mismatch("dist_valid_o", 64'(1), 64'(dist_valid_o));
            assert (dist_o == exp_dist[0])
                else value_mismatch("dist_o", 64'(exp_dist[0]), 64'(dist_o));
            void'(exp_due.pop_front());
            void'(exp_dist.pop_front());
        end else begin
            assert (dist_valid_o == 1'b0)
                else value_mismatch("dist_valid_o", 64'(0), 64'(dist_valid_o));
        end
    endtask

    task automatic check_wishbone();
        if (host_state != HOST_IDLE) wb_wait++;
        if (wbs_ack_o) begin
            assert (host_state == HOST_GRANTED && cycle_cnt == ack_due)
                else abort_run($sformatf("Wishbone ack at cycle %0d was not expected",
                                         cycle_cnt));
            if (!mw_we) begin
                assert (wbs_dat_o == exp_rdata)
                    else value_mismatch("wbs_dat_o", 64'(exp_rdata), 64'(wbs_dat_o));
            end
            host_state = HOST_IDLE;
        end else begin
            assert (host_state != HOST_GRANTED || cycle_cnt < ack_due)
                else abort_run("Wishbone ack missing in the cycle after the grant path");
            assert (wb_wait <= WB_ACK_BOUND)
                else abort_run($sformatf("Wishbone ack did not arrive within %0d cycles",
                                         WB_ACK_BOUND));
        end
    endtask

    // One rising edge: check outputs, then update the model with the inputs it sampled
    task automatic clock_step();
        @(posedge clk);
        cycle_cnt++;
        check_distance();
        check_wishbone();
        if (dist_start_i) begin
            exp_due.push_back(cycle_cnt + 3);   // Row as it was before this edge
            exp_dist.push_back(expected_sad(model_mem[dist_addr_i], dist_probe_i));
        end
        if (patch_wr_i) begin
            model_mem[patch_addr_i] = ram_word_t'(patch_data_i);
        end else if (host_state == HOST_PENDING) begin
            if (mw_we) begin
                model_mem[mw_row][int'(mw_lane) * 8 +: 8] = mw_byte;
                ack_due = cycle_cnt + 1;
            end else begin
                exp_rdata = mw_hi ? 32'(model_mem[mw_row][PATCH_BITS-1:32])
                                  : model_mem[mw_row][31:0];
                ack_due = cycle_cnt + 2;
            end
            host_state = HOST_GRANTED;
        end
        if (host_state == HOST_STROBE) host_state = HOST_PENDING;   // Bridge latched
    endtask

    task automatic start_wishbone(input logic is_write, input logic narrow);
        logic [31:0] dat;
        dat     = $urandom;
        mw_we   = is_write;
        mw_row  = pick_row(narrow);
        mw_lane = 3'($urandom);
        mw_byte = 8'($urandom);
        mw_hi   = 1'($urandom);
        if (is_write) begin
            dat[13:11] = mw_lane;
            dat[7:0]   = mw_byte;
        end else begin
            dat[11] = mw_hi;
        end
        wbs_cyc_i <= 1'b1;
        wbs_stb_i <= 1'b1;
        wbs_we_i  <= is_write;
        wbs_sel_i <= 4'($urandom);
        // Upper address bits beyond the row wrap away
        wbs_adr_i <= `WB_ADDR_OFFSET + 32'(mw_row) + 32'($urandom_range(0, 3)) * 32'd512;
        wbs_dat_i <= dat;
        host_state = HOST_STROBE;
        wb_wait    = 0;
    endtask

    task automatic load_all_rows();
        for (int r = 0; r < `RAM_DEPTH; r++) begin
            clock_step();
            patch_wr_i   <= 1'b1;
            patch_addr_i <= row_addr_t'(r);
            patch_data_i <= rand_patch();
        end
    endtask

    task automatic run_phase(input int n_cycles, input int native_pct, input int max_burst,
                             input int wb_pct, input int wb_wr_pct, input int dist_pct,
                             input logic narrow);
        int        burst_left;
        logic      native_now;
        row_addr_t na_addr;
        row_addr_t da;
        burst_left = 0;
        for (int i = 0; i < n_cycles; i++) begin
            clock_step();
            // Native bursts, always one idle cycle in between
            native_now = 1'b0;
            if (burst_left > 0) begin
                na_addr = pick_row(narrow);
                patch_wr_i   <= 1'b1;
                patch_addr_i <= na_addr;
                patch_data_i <= rand_patch();
                native_now = 1'b1;
                burst_left--;
            end else begin
                patch_wr_i <= 1'b0;
                if (int'($urandom_range(0, 99)) < native_pct) begin
                    burst_left = int'($urandom_range(1, max_burst));
                end
            end
            if (int'($urandom_range(0, 99)) < dist_pct) begin
                da = pick_row(narrow);
                if (native_now && $urandom_range(0, 1) == 1) begin
                    da = na_addr;   // Read the row being written at the same edge
                end
                dist_start_i <= 1'b1;
                dist_addr_i  <= da;
                dist_probe_i <= ($urandom_range(0, 7) == 0) ? patch_t'(model_mem[da])
                                                            : rand_patch();
            end else begin
                dist_start_i <= 1'b0;
            end
            if (host_state == HOST_IDLE) begin
                if (wbs_stb_i) begin
                    wbs_cyc_i <= 1'b0;   // Acked at this edge
                    wbs_stb_i <= 1'b0;
                end else if (int'($urandom_range(0, 99)) < wb_pct) begin
                    start_wishbone(int'($urandom_range(0, 99)) < wb_wr_pct, narrow);
                end
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n_i      <= 1'b0;
        patch_wr_i   <= 1'b0;
        patch_addr_i <= '0;
        patch_data_i <= '0;
        wbs_cyc_i    <= 1'b0;
        wbs_stb_i    <= 1'b0;
        wbs_we_i     <= 1'b0;
        wbs_sel_i    <= '0;
        wbs_adr_i    <= '0;
        wbs_dat_i    <= '0;
        dist_start_i <= 1'b0;
        dist_addr_i  <= '0;
        dist_probe_i <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;

        run_phase(N_IDLE, 0, 1, 0, 0, 0, 1'b0);        // Outputs quiet after reset
        load_all_rows();
        run_phase(N_DIST, 0, 1, 0, 0, 90, 1'b0);       // Back-to-back queries
        run_phase(N_WB, 0, 1, 100, 50, 0, 1'b1);       // Byte writes and half reads
        run_phase(N_CONT, 70, 12, 100, 60, 30, 1'b1);  // Wishbone against native bursts
        run_phase(N_READ, 0, 1, 100, 0, 80, 1'b1);     // Read back final contents
        run_phase(N_MIX, 30, 4, 50, 50, 50, 1'b1);
        run_phase(N_READ, 0, 1, 100, 0, 80, 1'b1);
        run_phase(N_DRAIN, 0, 1, 0, 0, 0, 1'b0);

        if (exp_due.size() != 0 || host_state != HOST_IDLE) begin
            abort_run("Distance results or a Wishbone cycle still outstanding at the end");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("Watchdog timeout, the run did not finish in time");
    end

endmodule
